// File: build.f
src/team_03_pkg.sv
src/gpio_cmd_decoder.sv
src/core_ctrl.sv
src/txn_regs.sv
src/gpio_result_port.sv
src/wishbone_manager.sv
src/team_03.sv
tests/team_03_asserts.sv
tests/team_03_tb.sv

// File: Bender.yml
package:
  name: team_03

sources:
  - src/team_03_pkg.sv
  - src/gpio_cmd_decoder.sv
  - src/core_ctrl.sv
  - src/txn_regs.sv
  - src/gpio_result_port.sv
  - src/wishbone_manager.sv
  - src/team_03.sv
  - target: test
    files:
      - tests/team_03_asserts.sv
      - tests/team_03_tb.sv

// File: tests/team_03_tb.sv
/*
 * Testbench for the GPIO command to Wishbone bridge.
 * Table of pin commands, Wishbone memory slave with random ack
 * delays and a reference memory updated from the table.
 */
`timescale 1ns/1ps
`default_nettype none

module team_03_tb;
    import team_03_pkg::*;

    localparam int DONE_TIMEOUT = 50;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              en;
    logic [GPIO_W-1:0] gpio_in;
    logic [GPIO_W-1:0] gpio_out;
    logic [GPIO_W-1:0] gpio_oeb;
    wb_addr_t          wb_adr;
    wb_data_t          wb_dat_wr;
    wb_sel_t           wb_sel;
    logic              wb_we;
    logic              wb_stb;
    logic              wb_cyc;
    wb_data_t          wb_dat_rd = '0;
    logic              wb_ack = 1'b0;

    // Slave model state
    wb_data_t    mem [16];
    logic        in_cycle = 1'b0;
    int          wait_left = 0;
    int          delay;
    int unsigned lcg_state = 69;
    int          write_acks = 0;

    // Monitors
    int cyc_cycles = 0;
    int busy_errors = 0;

    // Reference model
    wb_data_t ref_mem [16];
    wb_addr_t ref_addr = '0;
    wb_data_t ref_data = '0;
    wb_sel_t  ref_sel = '0;

    // Stimulus table columns
    cmd_code_t row_code [$];
    cmd_byte_t row_byte [$];
    logic      row_en [$];
    int        row_hold [$];
    bit        row_wait [$];
    bit        row_acc [$];
    bit        row_chk [$];
    cmd_byte_t row_exp [$];

    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;

    team_03 u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (en),
        .gpio_in   (gpio_in),
        .gpio_out  (gpio_out),
        .gpio_oeb  (gpio_oeb),
        .wb_adr    (wb_adr),
        .wb_dat_wr (wb_dat_wr),
        .wb_sel    (wb_sel),
        .wb_we     (wb_we),
        .wb_stb    (wb_stb),
        .wb_cyc    (wb_cyc),
        .wb_dat_rd (wb_dat_rd),
        .wb_ack    (wb_ack)
    );

    // 4 ns period
    always #2 clk = ~clk;

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    // Power-up contents, every word distinct
    function automatic wb_data_t fill_word(input int i);
        return 32'h0F1E_2D3C ^ (i * 32'h1111_1111);
    endfunction

    // Memory slave, word index from address bits 5 to 2
    always @(negedge clk) begin
        if (!rst_n) begin
            wb_ack   <= 1'b0;
            in_cycle <= 1'b0;
            for (int i = 0; i < 16; i++) begin
                mem[i] <= fill_word(i);
            end
        end else if (wb_ack) begin
            wb_ack <= 1'b0;
        end else if (wb_cyc && wb_stb) begin
            // 0 to 3 wait cycles, drawn once per transfer
            if (in_cycle) begin
                delay = wait_left;
            end else begin
                delay = int'(lcg_next() % 4);
            end
            if (delay == 0) begin
                wb_ack    <= 1'b1;
                in_cycle  <= 1'b0;
                wb_dat_rd <= mem[wb_adr[5:2]];
                if (wb_we) begin
                    write_acks <= write_acks + 1;
                    for (int l = 0; l < 4; l++) begin
                        if (wb_sel[l]) begin
                            mem[wb_adr[5:2]][8*l +: 8] <= wb_dat_wr[8*l +: 8];
                        end
                    end
                end
            end else begin
                in_cycle  <= 1'b1;
                wait_left <= delay - 1;
            end
        end
    end

    // Open bus cycles, for the en-low rows
    always @(posedge clk) begin
        if (wb_cyc) begin
            cyc_cycles <= cyc_cycles + 1;
        end
    end

    // Busy pin must follow wb_cyc
    always @(negedge clk) begin
        if (rst_n && gpio_out[PIN_BUSY] !== wb_cyc) begin
            $display("Fail: gpio_out[%0d] = %h, wb_cyc = %h", PIN_BUSY,
                     gpio_out[PIN_BUSY], wb_cyc);
            busy_errors <= busy_errors + 1;
        end
    end

    task automatic add_row(input cmd_code_t code, input cmd_byte_t data, input logic row_en_lvl,
                           input int hold, input bit wt, input bit acc, input bit chk,
                           input cmd_byte_t exp);
        row_code.push_back(code);
        row_byte.push_back(data);
        row_en.push_back(row_en_lvl);
        row_hold.push_back(hold);
        row_wait.push_back(wt);
        row_acc.push_back(acc);
        row_chk.push_back(chk);
        row_exp.push_back(exp);
    endtask

    task automatic build_table();
        // Address 0x14, data DEADBEEF, all lanes, write
        add_row(CMD_ADDR, 8'h00, 1, 4, 0, 1, 0, 8'h00);
        add_row(CMD_ADDR, 8'h00, 1, 4, 0, 1, 0, 8'h00);
        add_row(CMD_ADDR, 8'h00, 1, 4, 0, 1, 0, 8'h00);
        add_row(CMD_ADDR, 8'h14, 1, 4, 0, 1, 0, 8'h00);
        add_row(CMD_DATA, 8'hDE, 1, 4, 0, 1, 0, 8'h00);
        add_row(CMD_DATA, 8'hAD, 1, 4, 0, 1, 0, 8'h00);
        add_row(CMD_DATA, 8'hBE, 1, 4, 0, 1, 0, 8'h00);
        add_row(CMD_DATA, 8'hEF, 1, 4, 0, 1, 0, 8'h00);
        add_row(CMD_SEL, 8'h0F, 1, 4, 0, 1, 0, 8'h00);
        add_row(CMD_WRITE, 8'h00, 1, 4, 1, 1, 0, 8'h00);
        // Readback, then every byte in turn
        add_row(CMD_READ, 8'h00, 1, 4, 1, 1, 1, 8'hEF);
        add_row(CMD_SHOW, 8'h00, 1, 4, 0, 1, 1, 8'hEF);
        add_row(CMD_SHOW, 8'h01, 1, 4, 0, 1, 1, 8'hBE);
        add_row(CMD_SHOW, 8'h02, 1, 4, 0, 1, 1, 8'hAD);
        add_row(CMD_SHOW, 8'h03, 1, 4, 0, 1, 1, 8'hDE);
        // Lane 1 only
        add_row(CMD_DATA, 8'h11, 1, 4, 0, 1, 0, 8'h00);
        add_row(CMD_DATA, 8'h22, 1, 4, 0, 1, 0, 8'h00);
        add_row(CMD_DATA, 8'h33, 1, 4, 0, 1, 0, 8'h00);
        add_row(CMD_DATA, 8'h44, 1, 4, 0, 1, 0, 8'h00);
        add_row(CMD_SEL, 8'h02, 1, 4, 0, 1, 0, 8'h00);
        add_row(CMD_WRITE, 8'h00, 1, 4, 1, 1, 0, 8'h00);
        add_row(CMD_READ, 8'h00, 1, 4, 1, 1, 1, 8'hDE);
        add_row(CMD_SHOW, 8'h01, 1, 4, 0, 1, 1, 8'h33);
        add_row(CMD_SHOW, 8'h00, 1, 4, 0, 1, 1, 8'hEF);
        // Disabled, nothing may happen
        add_row(CMD_ADDR, 8'h08, 0, 4, 0, 0, 0, 8'h00);
        add_row(CMD_ADDR, 8'h08, 0, 4, 0, 0, 0, 8'h00);
        add_row(CMD_READ, 8'h00, 0, 4, 0, 0, 0, 8'h00);
        add_row(CMD_WRITE, 8'h00, 0, 4, 0, 0, 0, 8'h00);
        add_row(CMD_READ, 8'h00, 1, 4, 1, 1, 1, 8'hEF);
        add_row(CMD_SHOW, 8'h01, 1, 4, 0, 1, 1, 8'h33);
        // Back-to-back commands, second lands while busy
        add_row(CMD_SEL, 8'h0F, 1, 4, 0, 1, 0, 8'h00);
        add_row(CMD_READ, 8'h00, 1, 1, 0, 1, 0, 8'h00);
        add_row(CMD_WRITE, 8'h00, 1, 1, 1, 0, 1, 8'h33);
        add_row(CMD_SHOW, 8'h02, 1, 4, 0, 1, 1, 8'hAD);
        add_row(CMD_READ, 8'h00, 1, 1, 0, 1, 0, 8'h00);
        add_row(CMD_SHOW, 8'h00, 1, 1, 1, 0, 1, 8'hAD);
    endtask

    task automatic finish_test(input string label, input int err_start, input int busy_start);
        tests_run++;
        if (errors != err_start || busy_errors != busy_start) begin
            tests_failed++;
            $display("%s: errors", label);
        end else begin
            $display("%s: ok", label);
        end
    endtask

    task automatic check_reset();
        int err_start;
        int busy_start;
        logic [GPIO_W-1:0] oeb_exp;
        err_start  = errors;
        busy_start = busy_errors;
        // Outputs on pins 12 to 21, inputs elsewhere
        for (int i = 0; i < GPIO_W; i++) begin
            oeb_exp[i] = !(i >= PIN_RES_LSB && i <= PIN_DONE);
        end
        if (gpio_out[PIN_DONE:PIN_RES_LSB] !== '0) begin
            $display("Fail reset: gpio_out[21:12] = %h, expected 000",
                     gpio_out[PIN_DONE:PIN_RES_LSB]);
            errors++;
        end
        if (gpio_oeb !== oeb_exp) begin
            $display("Fail reset: gpio_oeb = %h, expected %h", gpio_oeb, oeb_exp);
            errors++;
        end
        if (wb_cyc !== 1'b0 || wb_stb !== 1'b0) begin
            $display("Fail reset: wb_cyc = %h wb_stb = %h, expected 0", wb_cyc, wb_stb);
            errors++;
        end
        finish_test("reset", err_start, busy_start);
    endtask

    task automatic apply_row(input int r);
        int waited;
        int err_start;
        int busy_start;
        int cyc_start;
        int wr_start;
        int idx;
        int low_cycles;
        cmd_byte_t shown;
        err_start  = errors;
        busy_start = busy_errors;
        cyc_start  = cyc_cycles;
        wr_start   = write_acks;
        // Short pulses get a longer gap so the fields outlast the decoder capture
        low_cycles = (row_hold[r] < 2) ? 2 : row_hold[r];
        // Fields and strobe change together on the falling edge
        en = row_en[r];
        gpio_in[PIN_BYTE_LSB +: 8] = row_byte[r];
        gpio_in[PIN_CMD_LSB +: 3]  = row_code[r];
        gpio_in[PIN_STROBE]        = 1'b1;
        repeat (row_hold[r]) @(negedge clk);
        gpio_in[PIN_STROBE] = 1'b0;
        repeat (low_cycles) @(negedge clk);
        if (row_wait[r]) begin
            waited = 0;
            while (!gpio_out[PIN_DONE] && waited < DONE_TIMEOUT) begin
                @(negedge clk);
                waited++;
            end
            if (!gpio_out[PIN_DONE]) begin
                $display("Fail row %0d: done pin stayed low for %0d cycles", r, DONE_TIMEOUT);
                errors++;
            end
        end
        // Reference follows the command rules
        if (row_acc[r]) begin
            case (row_code[r])
                CMD_ADDR: ref_addr = {ref_addr[23:0], row_byte[r]};
                CMD_DATA: ref_data = {ref_data[23:0], row_byte[r]};
                CMD_SEL:  ref_sel = row_byte[r][3:0];
                CMD_WRITE: begin
                    for (int l = 0; l < 4; l++) begin
                        if (ref_sel[l]) begin
                            ref_mem[ref_addr[5:2]][8*l +: 8] = ref_data[8*l +: 8];
                        end
                    end
                end
                default: ;
            endcase
        end
        idx = ref_addr[5:2];
        if (row_code[r] == CMD_WRITE && row_acc[r] && write_acks == wr_start) begin
            $display("Fail row %0d: no write cycle with wb_we high was acknowledged", r);
            errors++;
        end
        if (row_wait[r] && mem[idx] !== ref_mem[idx]) begin
            $display("Fail row %0d: mem[%0d] = %h, expected %h", r, idx, mem[idx], ref_mem[idx]);
            errors++;
        end
        if (!row_en[r] && cyc_cycles != cyc_start) begin
            $display("Fail row %0d: a bus cycle started while en was low", r);
            errors++;
        end
        if (row_chk[r]) begin
            shown = gpio_out[PIN_RES_LSB +: 8];
            if (shown !== row_exp[r]) begin
                $display("Fail row %0d: gpio_out[19:12] = %h, expected %h", r, shown, row_exp[r]);
                errors++;
            end
        end
        finish_test($sformatf("row %0d code %0d byte %h", r, row_code[r], row_byte[r]),
                    err_start, busy_start);
    endtask

    task automatic check_memory();
        int err_start;
        int busy_start;
        err_start  = errors;
        busy_start = busy_errors;
        for (int i = 0; i < 16; i++) begin
            if (mem[i] !== ref_mem[i]) begin
                $display("Fail memory: mem[%0d] = %h, expected %h", i, mem[i], ref_mem[i]);
                errors++;
            end
        end
        finish_test("final memory", err_start, busy_start);
    endtask

    initial begin
        rst_n   = 1'b0;
        en      = 1'b0;
        gpio_in = '0;
        for (int i = 0; i < 16; i++) begin
            ref_mem[i] = fill_word(i);
        end
        build_table();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_reset();
        for (int r = 0; r < row_code.size(); r++) begin
            apply_row(r);
        end
        check_memory();
        $display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
                 errors + busy_errors + u_dut.u_asserts.fail_count);
        if (tests_failed == 0 && errors == 0 && busy_errors == 0
            && u_dut.u_asserts.fail_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/team_03_asserts.sv
/*
 * Wishbone protocol and busy pin checks for the bridge top.
 * The bus signals are the chip's own wb_* ports.
 */
`timescale 1ns/1ps
`default_nettype none

module team_03_asserts (
    input wire logic                           clk,
    input wire logic                           rst_n,
    input wire logic [team_03_pkg::GPIO_W-1:0] gpio_out,
    input wire team_03_pkg::wb_addr_t          wb_adr,
    input wire team_03_pkg::wb_data_t          wb_dat_wr,
    input wire team_03_pkg::wb_sel_t           wb_sel,
    input wire logic                           wb_we,
    input wire logic                           wb_stb,
    input wire logic                           wb_cyc,
    input wire logic                           wb_ack
);
    import team_03_pkg::*;

    // Number of assertion failures so far
    int unsigned fail_count = 0;

    // Strobe only inside an open cycle
    a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n) wb_stb |-> wb_cyc)
        else begin
            $error("wb_stb high while wb_cyc is low");
            fail_count++;
        end

    // Request frozen until the slave acks
    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr) && $stable(wb_dat_wr)
                                 && $stable(wb_sel) && $stable(wb_we)))
        else begin
            $error("Wishbone request changed before ack");
            fail_count++;
        end

    // Bus idle right after a reset edge
    a_reset_idle: assert property (@(posedge clk) !rst_n |=> (!wb_cyc && !wb_stb))
        else begin
            $error("wb_cyc or wb_stb high in the cycle after reset");
            fail_count++;
        end

    // Busy pin mirrors the open cycle
    a_busy_pin: assert property (@(posedge clk) disable iff (!rst_n)
        gpio_out[PIN_BUSY] == wb_cyc)
        else begin
            $error("busy pin differs from wb_cyc");
            fail_count++;
        end

endmodule

bind team_03 team_03_asserts u_asserts (
    .clk       (clk),
    .rst_n     (rst_n),
    .gpio_out  (gpio_out),
    .wb_adr    (wb_adr),
    .wb_dat_wr (wb_dat_wr),
    .wb_sel    (wb_sel),
    .wb_we     (wb_we),
    .wb_stb    (wb_stb),
    .wb_cyc    (wb_cyc),
    .wb_ack    (wb_ack)
);

`default_nettype wire

// File: src/team_03.sv
/*
 * Chip top for the GPIO command to Wishbone bridge.
 * Connects command decode, control, transfer registers,
 * result pins and the bus manager.
 */
`timescale 1ns/1ps
`default_nettype none

module team_03 (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic                        en,
    input  wire logic [team_03_pkg::GPIO_W-1:0] gpio_in,
    output logic [team_03_pkg::GPIO_W-1:0]   gpio_out,
    output logic [team_03_pkg::GPIO_W-1:0]   gpio_oeb,
    output team_03_pkg::wb_addr_t            wb_adr,
    output team_03_pkg::wb_data_t            wb_dat_wr,
    output team_03_pkg::wb_sel_t             wb_sel,
    output logic                             wb_we,
    output logic                             wb_stb,
    output logic                             wb_cyc,
    input  wire team_03_pkg::wb_data_t       wb_dat_rd,
    input  wire logic                        wb_ack
);
    import team_03_pkg::*;

    // Decoded command
    logic      cmd_valid;
    cmd_code_t cmd_code;
    cmd_byte_t cmd_byte;

    // Control strobes
    logic addr_shift, data_shift, sel_load, show_load;
    logic start_write, start_read;
    logic done;

    // Transfer request and result
    wb_addr_t addr;
    wb_data_t wr_data;
    wb_sel_t  sel;
    wb_data_t rd_data;
    logic     xfer_done;
    logic     busy;

    gpio_cmd_decoder u_decoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .gpio_in   (gpio_in),
        .cmd_valid (cmd_valid),
        .cmd_code  (cmd_code),
        .cmd_byte  (cmd_byte)
    );

    core_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .en          (en),
        .cmd_valid   (cmd_valid),
        .cmd_code    (cmd_code),
        .xfer_done   (xfer_done),
        .addr_shift  (addr_shift),
        .data_shift  (data_shift),
        .sel_load    (sel_load),
        .show_load   (show_load),
        .start_write (start_write),
        .start_read  (start_read),
        .done        (done)
    );

    txn_regs u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .addr_shift (addr_shift),
        .data_shift (data_shift),
        .sel_load   (sel_load),
        .cmd_byte   (cmd_byte),
        .addr       (addr),
        .wr_data    (wr_data),
        .sel        (sel)
    );

    gpio_result_port u_result (
        .clk       (clk),
        .rst_n     (rst_n),
        .show_load (show_load),
        .cmd_byte  (cmd_byte),
        .xfer_done (xfer_done),
        .rd_data   (rd_data),
        .busy      (busy),
        .done      (done),
        .gpio_out  (gpio_out),
        .gpio_oeb  (gpio_oeb)
    );

    wishbone_manager u_wb (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_write (start_write),
        .start_read  (start_read),
        .addr        (addr),
        .wr_data     (wr_data),
        .sel         (sel),
        .rd_data     (rd_data),
        .xfer_done   (xfer_done),
        .busy        (busy),
        .wb_adr      (wb_adr),
        .wb_dat_wr   (wb_dat_wr),
        .wb_sel      (wb_sel),
        .wb_we       (wb_we),
        .wb_stb      (wb_stb),
        .wb_cyc      (wb_cyc),
        .wb_dat_rd   (wb_dat_rd),
        .wb_ack      (wb_ack)
    );

endmodule

`default_nettype wire

// File: src/wishbone_manager.sv
/*
 * Wishbone manager for classic single transfers. Registers the
 * request on start, holds cyc and stb until ack, returns read data.
 */
`timescale 1ns/1ps
`default_nettype none

module wishbone_manager (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  start_write,
    input  wire logic                  start_read,
    input  wire team_03_pkg::wb_addr_t addr,
    input  wire team_03_pkg::wb_data_t wr_data,
    input  wire team_03_pkg::wb_sel_t  sel,
    output team_03_pkg::wb_data_t      rd_data,
    output logic                       xfer_done,
    output logic                       busy,
    output team_03_pkg::wb_addr_t      wb_adr,
    output team_03_pkg::wb_data_t      wb_dat_wr,
    output team_03_pkg::wb_sel_t       wb_sel,
    output logic                       wb_we,
    output logic                       wb_stb,
    output logic                       wb_cyc,
    input  wire team_03_pkg::wb_data_t wb_dat_rd,
    input  wire logic                  wb_ack
);

    logic start;
    logic ack_seen;

    // A start during an open cycle is ignored
    assign start    = (start_write || start_read) && !wb_cyc;
    assign ack_seen = wb_cyc && wb_ack;

    // Open cycle means busy
    assign busy = wb_cyc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_cyc    <= 1'b0;
            wb_stb    <= 1'b0;
            wb_we     <= 1'b0;
            wb_adr    <= '0;
            wb_dat_wr <= '0;
            wb_sel    <= '0;
            rd_data   <= '0;
            xfer_done <= 1'b0;
        end else begin
            xfer_done <= ack_seen;
            if (start) begin
                // Request fields stay frozen until ack
                wb_cyc    <= 1'b1;
                wb_stb    <= 1'b1;
                wb_we     <= start_write;
                wb_adr    <= addr;
                wb_dat_wr <= wr_data;
                wb_sel    <= sel;
            end else if (ack_seen) begin
                wb_cyc <= 1'b0;
                wb_stb <= 1'b0;
                wb_we  <= 1'b0;
                // Only reads update the returned word
                if (!wb_we) begin
                    rd_data <= wb_dat_rd;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: src/gpio_result_port.sv
/*
 * Result pins. Holds the last read word, picks the shown byte and
 * drives the result, busy and done pins with their directions.
 */
`timescale 1ns/1ps
`default_nettype none

module gpio_result_port (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic                        show_load,
    input  wire team_03_pkg::cmd_byte_t      cmd_byte,
    input  wire logic                        xfer_done,
    input  wire team_03_pkg::wb_data_t       rd_data,
    input  wire logic                        busy,
    input  wire logic                        done,
    output logic [team_03_pkg::GPIO_W-1:0]   gpio_out,
    output logic [team_03_pkg::GPIO_W-1:0]   gpio_oeb
);
    import team_03_pkg::*;

    wb_data_t  rd_word;
    logic [1:0] show_idx;
    cmd_byte_t  shown_byte;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_word  <= '0;
            show_idx <= '0;
        end else begin
            // Manager holds rd_data over writes, so reload every time
            if (xfer_done) begin
                rd_word <= rd_data;
            end
            if (show_load) begin
                show_idx <= cmd_byte[1:0];
            end
        end
    end

    assign shown_byte = rd_word[show_idx*8 +: 8];

    // Unused outputs stay low
    always_comb begin
        gpio_out = '0;
        gpio_out[PIN_RES_LSB +: $bits(cmd_byte_t)] = shown_byte;
        gpio_out[PIN_BUSY] = busy;
        gpio_out[PIN_DONE] = done;
    end

    // Active-low enables, result through done pins drive out
    always_comb begin
        gpio_oeb = '1;
        gpio_oeb[PIN_DONE:PIN_RES_LSB] = '0;
    end

endmodule

`default_nettype wire

// File: src/txn_regs.sv
/*
 * Transfer request registers. Address and write data are built a
 * byte at a time, the lane select loads from a single byte.
 */
`timescale 1ns/1ps
`default_nettype none

module txn_regs (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   addr_shift,
    input  wire logic                   data_shift,
    input  wire logic                   sel_load,
    input  wire team_03_pkg::cmd_byte_t cmd_byte,
    output team_03_pkg::wb_addr_t       addr,
    output team_03_pkg::wb_data_t       wr_data,
    output team_03_pkg::wb_sel_t        sel
);

    // Values persist across transfers
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            addr    <= '0;
            wr_data <= '0;
            sel     <= '0;
        end else begin
            // New byte enters at the bottom, older bytes move up
            if (addr_shift) begin
                addr <= {addr[$bits(addr)-$bits(cmd_byte)-1:0], cmd_byte};
            end
            if (data_shift) begin
                wr_data <= {wr_data[$bits(wr_data)-$bits(cmd_byte)-1:0], cmd_byte};
            end
            // Only the low nibble matters
            if (sel_load) begin
                sel <= cmd_byte[$bits(sel)-1:0];
            end
        end
    end

endmodule

`default_nettype wire

// File: src/core_ctrl.sv
/*
 * Control FSM. Accepts decoded commands when idle and enabled,
 * issues register load strobes or transfer starts and keeps
 * the done flag.
 */
`timescale 1ns/1ps
`default_nettype none

module core_ctrl (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   en,
    input  wire logic                   cmd_valid,
    input  wire team_03_pkg::cmd_code_t cmd_code,
    input  wire logic                   xfer_done,
    output logic                        addr_shift,
    output logic                        data_shift,
    output logic                        sel_load,
    output logic                        show_load,
    output logic                        start_write,
    output logic                        start_read,
    output logic                        done
);
    import team_03_pkg::*;

    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        BUS    = 2'd1,
        SETTLE = 2'd2
    } state_t;

    state_t state, state_next;
    logic   accept;

    // Commands only count when idle and enabled
    assign accept = cmd_valid && en && (state == IDLE);

    // Command decode, strobes last the single accept cycle
    always_comb begin
        addr_shift  = 1'b0;
        data_shift  = 1'b0;
        sel_load    = 1'b0;
        show_load   = 1'b0;
        start_write = 1'b0;
        start_read  = 1'b0;
        if (accept) begin
            case (cmd_code)
                CMD_ADDR:  addr_shift  = 1'b1;
                CMD_DATA:  data_shift  = 1'b1;
                CMD_SEL:   sel_load    = 1'b1;
                CMD_SHOW:  show_load   = 1'b1;
                CMD_WRITE: start_write = 1'b1;
                CMD_READ:  start_read  = 1'b1;
                // NOP and code 7
                default:   ;
            endcase
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (start_write || start_read) begin
                    state_next = BUS;
                end
            end
            BUS: begin
                if (xfer_done) begin
                    state_next = SETTLE;
                end
            end
            // One dead cycle so a command in the done cycle is dropped
            SETTLE:  state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
            done  <= 1'b0;
        end else begin
            state <= state_next;
            // Cleared on start, set at the end of the transfer
            if (start_write || start_read) begin
                done <= 1'b0;
            end else if (xfer_done) begin
                done <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/gpio_cmd_decoder.sv
/*
 * GPIO command decoder. Synchronizes the strobe pin, detects its
 * rising edge and captures the code and byte fields.
 */
`timescale 1ns/1ps
`default_nettype none

module gpio_cmd_decoder (
    input  wire logic                           clk,
    input  wire logic                           rst_n,
    input  wire logic [team_03_pkg::GPIO_W-1:0] gpio_in,
    output logic                                cmd_valid,
    output team_03_pkg::cmd_code_t              cmd_code,
    output team_03_pkg::cmd_byte_t              cmd_byte
);
    import team_03_pkg::*;

    logic strobe_meta;
    logic strobe_sync;
    logic strobe_prev;
    logic strobe_rise;

    // High for one cycle after the synced strobe goes up
    assign strobe_rise = strobe_sync && !strobe_prev;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            strobe_meta <= 1'b0;
            strobe_sync <= 1'b0;
            strobe_prev <= 1'b0;
            cmd_valid   <= 1'b0;
            cmd_code    <= CMD_NOP;
            cmd_byte    <= '0;
        end else begin
            // Two-flop synchronizer, then edge history
            strobe_meta <= gpio_in[PIN_STROBE];
            strobe_sync <= strobe_meta;
            strobe_prev <= strobe_sync;
            cmd_valid   <= strobe_rise;
            // Latch fields with the edge, pins may move afterwards
            if (strobe_rise) begin
                cmd_code <= gpio_in[PIN_CMD_LSB +: $bits(cmd_code_t)];
                cmd_byte <= gpio_in[PIN_BYTE_LSB +: $bits(cmd_byte_t)];
            end
        end
    end

endmodule

`default_nettype wire

// File: src/team_03_pkg.sv
/*
 * Shared definitions for the GPIO command to Wishbone bridge.
 * Bus field widths, command codes and the GPIO pin map.
 */
`default_nettype none

package team_03_pkg;

    // Wishbone bus fields
    typedef logic [31:0] wb_addr_t;
    typedef logic [31:0] wb_data_t;
    typedef logic [3:0]  wb_sel_t;

    // Command fields from the pins
    typedef logic [7:0]  cmd_byte_t;
    typedef logic [2:0]  cmd_code_t;

    // Command codes, code 7 falls back to NOP
    localparam cmd_code_t CMD_NOP   = 3'd0;
    // Byte shifts in at the bottom
    localparam cmd_code_t CMD_ADDR  = 3'd1;
    localparam cmd_code_t CMD_DATA  = 3'd2;
    // Low nibble becomes the lane select
    localparam cmd_code_t CMD_SEL   = 3'd3;
    localparam cmd_code_t CMD_WRITE = 3'd4;
    localparam cmd_code_t CMD_READ  = 3'd5;
    // Low 2 bits pick the shown read byte
    localparam cmd_code_t CMD_SHOW  = 3'd6;

    // GPIO pin map
    localparam int GPIO_W       = 34;
    localparam int PIN_BYTE_LSB = 0;
    localparam int PIN_CMD_LSB  = 8;
    localparam int PIN_STROBE   = 11;
    localparam int PIN_RES_LSB  = 12;
    localparam int PIN_BUSY     = 20;
    localparam int PIN_DONE     = 21;

endpackage

`default_nettype wire
